/* rtl/kbd_cfg.svh */
`ifndef KBD_CFG_SVH
`define KBD_CFG_SVH

// Number of equal clk samples of ps2_clk before the filtered level follows it.
`define KBD_FILTER_LEN 4

// Entries in the output character FIFO. Must be a power of two.
`define KBD_FIFO_DEPTH 8

`endif

/* rtl/kbd_pkg.sv */
package kbd_pkg;

	// One byte as sent by the keyboard.
	typedef logic [7:0] scan_byte_t;

	// A 7-bit ASCII character.
	typedef logic [6:0] ascii_t;

	// A make event with the modifier state seen when the key went down.
	typedef struct packed {
		scan_byte_t code;
		logic       extended; // E0 came before the code.
		logic       shift;    // Either shift key held.
		logic       ctrl;     // Either control key held.
		logic       caps;     // Caps lock state.
	} key_event_t;

	// Sticky error flags, cleared only by reset.
	typedef struct packed {
		logic frame_error;
		logic overrun;
	} kbd_status_t;

	// Prefixes still pending in the decoder.
	typedef enum logic [1:0] {
		dec_idle    = 2'd0,
		dec_brk     = 2'd1,
		dec_ext     = 2'd2,
		dec_ext_brk = 2'd3
	} dec_state_t;

endpackage

/* rtl/ps2_frame_rx.sv */
`timescale 1ns/100ps

`include "kbd_cfg.svh"

module ps2_frame_rx (
	input  logic                clk,
	input  logic                rst,
	input  logic                ps2_clk,
	input  logic                ps2_data,
	output logic                byte_valid,
	input  logic                byte_ready,
	output kbd_pkg::scan_byte_t byte_data,
	output logic                frame_error,
	output logic                overrun
);

	localparam int FILTER_LEN = `KBD_FILTER_LEN;
	localparam int CNT_W = $clog2(FILTER_LEN + 1);

	logic [1:0]       clk_sync;
	logic [1:0]       data_sync;
	logic             clk_filt;  // Filtered ps2_clk level.
	logic [CNT_W-1:0] filt_cnt;
	logic             clk_fall;
	logic [9:0]       shreg;     // Bits received so far, first bit at the bottom.
	logic [3:0]       bit_cnt;
	logic [10:0]      frame;
	logic             frame_ok;
	logic             frame_done;
	logic             load;

	// The filtered clock is about to drop in this cycle.
	assign clk_fall = clk_filt && !clk_sync[1] && (filt_cnt == CNT_W'(FILTER_LEN - 1));

	// The whole frame as it looks with the bit being sampled now.
	assign frame = {data_sync[1], shreg};

	// Start bit low, stop bit high, odd parity over data and parity bit.
	assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);

	assign frame_done = clk_fall && (bit_cnt == 4'd10);

	// A good frame is kept only if the output register is free or being emptied.
	assign load = frame_done && frame_ok && (!byte_valid || byte_ready);

	always_ff @(posedge clk) begin
		if (rst) begin
			clk_sync    <= 2'b11; // Idle PS/2 lines are high.
			data_sync   <= 2'b11;
			clk_filt    <= 1'b1;
			filt_cnt    <= '0;
			bit_cnt     <= '0;
			byte_valid  <= 1'b0;
			frame_error <= 1'b0;
			overrun     <= 1'b0;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};

			// The filtered level moves only after a run of equal samples.
			if (clk_sync[1] == clk_filt) begin
				filt_cnt <= '0;
			end else if (filt_cnt == CNT_W'(FILTER_LEN - 1)) begin
				clk_filt <= clk_sync[1];
				filt_cnt <= '0;
			end else begin
				filt_cnt <= filt_cnt + 1'b1;
			end

			if (byte_ready) begin
				byte_valid <= 1'b0;
			end

			if (clk_fall) begin
				if (frame_done) begin
					bit_cnt <= '0;
					if (!frame_ok) begin
						frame_error <= 1'b1;
					end else if (!load) begin
						overrun <= 1'b1; // Previous byte not yet taken.
					end else begin
						byte_valid <= 1'b1;
					end
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (clk_fall) begin
			shreg <= frame[10:1];
		end
		if (load) begin
			byte_data <= frame[8:1];
		end
	end

endmodule

/* rtl/scan_decoder.sv */
`timescale 1ns/100ps

module scan_decoder (
	input  logic                clk,
	input  logic                rst,
	input  logic                byte_valid,
	output logic                byte_ready,
	input  kbd_pkg::scan_byte_t byte_data,
	output logic                evt_valid,
	input  logic                evt_ready,
	output kbd_pkg::key_event_t evt
);

	kbd_pkg::dec_state_t state;

	logic shift_l;
	logic shift_r;
	logic ctrl_l;
	logic ctrl_r;
	logic caps;
	logic take;
	logic is_brk;
	logic is_ext;
	logic is_mod;
	logic forward;

	assign byte_ready = !evt_valid || evt_ready;
	assign take = byte_valid && byte_ready;

	assign is_brk = (state == kbd_pkg::dec_brk) || (state == kbd_pkg::dec_ext_brk);
	assign is_ext = (state == kbd_pkg::dec_ext) || (state == kbd_pkg::dec_ext_brk);

	// Shift and caps lock are plain codes only; control exists in both forms.
	assign is_mod = (!is_ext && (byte_data == 8'h12 || byte_data == 8'h59 ||
		byte_data == 8'h58)) || (byte_data == 8'h14);

	// Only make codes of ordinary keys go on to the translator.
	assign forward = take && (byte_data != 8'hf0) && (byte_data != 8'he0) &&
		!is_mod && !is_brk;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= kbd_pkg::dec_idle;
			shift_l   <= 1'b0;
			shift_r   <= 1'b0;
			ctrl_l    <= 1'b0;
			ctrl_r    <= 1'b0;
			caps      <= 1'b0;
			evt_valid <= 1'b0;
		end else begin
			if (evt_ready) begin
				evt_valid <= 1'b0;
			end

			if (take) begin
				if (byte_data == 8'he0) begin
					state <= kbd_pkg::dec_ext;
				end else if (byte_data == 8'hf0) begin
					state <= is_ext ? kbd_pkg::dec_ext_brk : kbd_pkg::dec_brk;
				end else begin
					state <= kbd_pkg::dec_idle; // Every other byte ends the sequence.
					if (is_mod) begin
						case (byte_data)
							8'h12:   shift_l <= !is_brk;
							8'h59:   shift_r <= !is_brk;
							8'h58:   caps <= caps ^ !is_brk; // Toggles on make only.
							default: begin
								if (is_ext) begin
									ctrl_r <= !is_brk;
								end else begin
									ctrl_l <= !is_brk;
								end
							end
						endcase
					end
				end
			end

			if (forward) begin
				evt_valid <= 1'b1;
			end
		end
	end

	// The event payload carries a snapshot of the modifiers.
	always_ff @(posedge clk) begin
		if (forward) begin
			evt.code     <= byte_data;
			evt.extended <= is_ext;
			evt.shift    <= shift_l || shift_r;
			evt.ctrl     <= ctrl_l || ctrl_r;
			evt.caps     <= caps;
		end
	end

endmodule

/* rtl/ascii_translator.sv */
`timescale 1ns/100ps

module ascii_translator (
	input  logic                clk,
	input  logic                rst,
	input  logic                evt_valid,
	output logic                evt_ready,
	input  kbd_pkg::key_event_t evt,
	output logic                chr_valid,
	input  logic                chr_ready,
	output kbd_pkg::ascii_t     chr
);

	logic [4:0]      letter_idx; // Position in the alphabet, zero when not a letter.
	logic            sym_hit;
	kbd_pkg::ascii_t sym_lo;
	kbd_pkg::ascii_t sym_hi;
	logic            spec_hit;
	kbd_pkg::ascii_t spec_val;
	logic            map_hit;
	kbd_pkg::ascii_t map_val;
	logic            take;

	assign evt_ready = !chr_valid || chr_ready;
	assign take = evt_valid && evt_ready;

	// Set 2 make codes of the letter keys.
	always_comb begin
		case (evt.code)
			8'h1c: letter_idx = 5'd1;
			8'h32: letter_idx = 5'd2;
			8'h21: letter_idx = 5'd3;
			8'h23: letter_idx = 5'd4;
			8'h24: letter_idx = 5'd5;
			8'h2b: letter_idx = 5'd6;
			8'h34: letter_idx = 5'd7;
			8'h33: letter_idx = 5'd8;
			8'h43: letter_idx = 5'd9;
			8'h3b: letter_idx = 5'd10;
			8'h42: letter_idx = 5'd11;
			8'h4b: letter_idx = 5'd12;
			8'h3a: letter_idx = 5'd13;
			8'h31: letter_idx = 5'd14;
			8'h44: letter_idx = 5'd15;
			8'h4d: letter_idx = 5'd16;
			8'h15: letter_idx = 5'd17;
			8'h2d: letter_idx = 5'd18;
			8'h1b: letter_idx = 5'd19;
			8'h2c: letter_idx = 5'd20;
			8'h3c: letter_idx = 5'd21;
			8'h2a: letter_idx = 5'd22;
			8'h1d: letter_idx = 5'd23;
			8'h22: letter_idx = 5'd24;
			8'h35: letter_idx = 5'd25;
			8'h1a: letter_idx = 5'd26;
			default: letter_idx = 5'd0;
		endcase
	end

	// Digits and punctuation, unshifted and shifted form of each key.
	always_comb begin
		sym_hit = 1'b1;
		case (evt.code)
			8'h0e:   {sym_lo, sym_hi} = {7'h60, 7'h7e}; // ` ~
			8'h16:   {sym_lo, sym_hi} = {7'h31, 7'h21};
			8'h1e:   {sym_lo, sym_hi} = {7'h32, 7'h40};
			8'h26:   {sym_lo, sym_hi} = {7'h33, 7'h23};
			8'h25:   {sym_lo, sym_hi} = {7'h34, 7'h24};
			8'h2e:   {sym_lo, sym_hi} = {7'h35, 7'h25};
			8'h36:   {sym_lo, sym_hi} = {7'h36, 7'h5e};
			8'h3d:   {sym_lo, sym_hi} = {7'h37, 7'h26};
			8'h3e:   {sym_lo, sym_hi} = {7'h38, 7'h2a};
			8'h46:   {sym_lo, sym_hi} = {7'h39, 7'h28};
			8'h45:   {sym_lo, sym_hi} = {7'h30, 7'h29};
			8'h4e:   {sym_lo, sym_hi} = {7'h2d, 7'h5f}; // - _
			8'h55:   {sym_lo, sym_hi} = {7'h3d, 7'h2b};
			8'h54:   {sym_lo, sym_hi} = {7'h5b, 7'h7b};
			8'h5b:   {sym_lo, sym_hi} = {7'h5d, 7'h7d};
			8'h5d:   {sym_lo, sym_hi} = {7'h5c, 7'h7c}; // Backslash and bar.
			8'h4c:   {sym_lo, sym_hi} = {7'h3b, 7'h3a};
			8'h52:   {sym_lo, sym_hi} = {7'h27, 7'h22};
			8'h41:   {sym_lo, sym_hi} = {7'h2c, 7'h3c};
			8'h49:   {sym_lo, sym_hi} = {7'h2e, 7'h3e};
			8'h4a:   {sym_lo, sym_hi} = {7'h2f, 7'h3f};
			default: begin
				sym_hit = 1'b0;
				{sym_lo, sym_hi} = {7'h00, 7'h00};
			end
		endcase
	end

	// Space, backspace, tab, enter and escape ignore the modifiers.
	always_comb begin
		spec_hit = 1'b1;
		case (evt.code)
			8'h29:   spec_val = 7'h20;
			8'h66:   spec_val = 7'h08;
			8'h0d:   spec_val = 7'h09;
			8'h5a:   spec_val = 7'h0d;
			8'h76:   spec_val = 7'h1b;
			default: begin
				spec_hit = 1'b0;
				spec_val = 7'h00;
			end
		endcase
	end

	always_comb begin
		map_hit = 1'b1;
		map_val = 7'h00;
		if (evt.extended) begin
			map_hit = (evt.code == 8'h71) && !evt.ctrl; // Extended delete.
			map_val = 7'h7f;
		end else if (letter_idx != 5'd0) begin
			if (evt.ctrl) begin
				map_val = {2'b00, letter_idx};
			end else if (evt.shift ^ evt.caps) begin
				map_val = {2'b10, letter_idx}; // Upper case starts at 0x41.
			end else begin
				map_val = {2'b11, letter_idx};
			end
		end else if (evt.ctrl) begin
			map_hit = 1'b0;
		end else if (sym_hit) begin
			map_val = evt.shift ? sym_hi : sym_lo;
		end else begin
			map_hit = spec_hit;
			map_val = spec_val;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			chr_valid <= 1'b0;
		end else if (take && map_hit) begin
			chr_valid <= 1'b1;
		end else if (chr_ready) begin
			chr_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take && map_hit) begin
			chr <= map_val;
		end
	end

endmodule

/* rtl/char_fifo.sv */
`timescale 1ns/100ps

`include "kbd_cfg.svh"

module char_fifo (
	input  logic            clk,
	input  logic            rst,
	input  logic            in_valid,
	output logic            in_ready,
	input  kbd_pkg::ascii_t in_data,
	output logic            out_valid,
	input  logic            out_ready,
	output kbd_pkg::ascii_t out_data
);

	localparam int DEPTH = `KBD_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);

	kbd_pkg::ascii_t mem [DEPTH];

	// The top bit of each pointer counts wraps, so full and empty differ.
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        push;
	logic        pop;

	assign in_ready = !((wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]));
	assign out_valid = (wr_ptr != rd_ptr);
	assign out_data = mem[rd_ptr[AW-1:0]];

	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr[AW-1:0]] <= in_data;
		end
	end

endmodule

/* rtl/ps2_keyboard_top.sv */
`timescale 1ns/100ps

module ps2_keyboard_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ps2_clk,
	input  logic                 ps2_data,
	output logic                 char_valid,
	input  logic                 char_ready,
	output kbd_pkg::ascii_t      char_data,
	output kbd_pkg::kbd_status_t status
);

	logic                byte_valid;
	logic                byte_ready;
	kbd_pkg::scan_byte_t byte_data;
	logic                evt_valid;
	logic                evt_ready;
	kbd_pkg::key_event_t evt;
	logic                chr_valid;
	logic                chr_ready;
	kbd_pkg::ascii_t     chr;

	// Both status flags come from the receiver.
	ps2_frame_rx u_rx (
		.clk(clk), .rst(rst), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
		.byte_valid(byte_valid), .byte_ready(byte_ready), .byte_data(byte_data),
		.frame_error(status.frame_error), .overrun(status.overrun)
	);

	scan_decoder u_dec (
		.clk(clk), .rst(rst),
		.byte_valid(byte_valid), .byte_ready(byte_ready), .byte_data(byte_data),
		.evt_valid(evt_valid), .evt_ready(evt_ready), .evt(evt)
	);

	ascii_translator u_xlat (
		.clk(clk), .rst(rst),
		.evt_valid(evt_valid), .evt_ready(evt_ready), .evt(evt),
		.chr_valid(chr_valid), .chr_ready(chr_ready), .chr(chr)
	);

	char_fifo u_fifo (
		.clk(clk), .rst(rst),
		.in_valid(chr_valid), .in_ready(chr_ready), .in_data(chr),
		.out_valid(char_valid), .out_ready(char_ready), .out_data(char_data)
	);

endmodule

/* verification/ps2_keyboard_tb.sv */
`timescale 1ns/100ps

`include "kbd_cfg.svh"

module ps2_keyboard_tb;

	localparam int HALF_BIT = 20; // clk cycles in each ps2_clk phase.
	localparam int BUF_CHARS = `KBD_FIFO_DEPTH + 3;

	logic                 clk;
	logic                 rst;
	logic                 ps2_clk;
	logic                 ps2_data;
	logic                 char_valid;
	logic                 char_ready;
	kbd_pkg::ascii_t      char_data;
	kbd_pkg::kbd_status_t status;

	kbd_pkg::ascii_t      exp_q[$];
	kbd_pkg::kbd_status_t exp_status = '0;
	int                   ready_mode = 0; // 0 ready, 1 held low, 2 random stretches.
	int                   cycle_cnt = 0;
	int                   frames_sent = 0;
	int                   chars_seen = 0;
	int                   mismatches = 0;
	int                   other_errors = 0;

	// Host side model of the modifiers and pending prefixes.
	bit m_shift_l = 1'b0;
	bit m_shift_r = 1'b0;
	bit m_ctrl_l = 1'b0;
	bit m_ctrl_r = 1'b0;
	bit m_caps = 1'b0;
	bit m_ext = 1'b0;
	bit m_brk = 1'b0;

	// Set 2 make codes in alphabet order, and the symbol keys with their two legends.
	kbd_pkg::scan_byte_t letter_codes [26] = '{
		8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43, 8'h3b,
		8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d, 8'h1b, 8'h2c,
		8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a
	};
	kbd_pkg::scan_byte_t sym_codes [21] = '{
		8'h0e, 8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46,
		8'h45, 8'h4e, 8'h55, 8'h54, 8'h5b, 8'h5d, 8'h4c, 8'h52, 8'h41, 8'h49, 8'h4a
	};
	string letters = "abcdefghijklmnopqrstuvwxyz";
	string sym_plain = "`1234567890-=[]\\;',./";
	string sym_shift = "~!@#$%^&*()_+{}|:\"<>?";

	ps2_keyboard_top u_dut (
		.clk(clk), .rst(rst), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
		.char_valid(char_valid), .char_ready(char_ready), .char_data(char_data),
		.status(status)
	);

	always #4 clk = ~clk;

	// Feeds one received byte to the model; returns 1 when a character is due.
	function automatic bit ref_ascii(input kbd_pkg::scan_byte_t b, output kbd_pkg::ascii_t ch);
		bit brk;
		bit ext;
		bit shift;
		bit ctrl;
		ch = 7'h00;
		if (b == 8'he0) begin
			m_ext = 1'b1;
			return 1'b0;
		end
		if (b == 8'hf0) begin
			m_brk = 1'b1;
			return 1'b0;
		end
		brk = m_brk;
		ext = m_ext;
		m_brk = 1'b0;
		m_ext = 1'b0;
		if (!ext && b == 8'h12) m_shift_l = !brk;
		if (!ext && b == 8'h59) m_shift_r = !brk;
		if (!ext && b == 8'h58 && !brk) m_caps = !m_caps;
		if (b == 8'h14 && ext) m_ctrl_r = !brk;
		if (b == 8'h14 && !ext) m_ctrl_l = !brk;
		if (brk || b == 8'h14 || (!ext && (b == 8'h12 || b == 8'h59 || b == 8'h58))) begin
			return 1'b0;
		end
		shift = m_shift_l || m_shift_r;
		ctrl = m_ctrl_l || m_ctrl_r;
		if (ext) begin
			ch = 7'h7f;
			return (b == 8'h71) && !ctrl;
		end
		for (int i = 0; i < 26; i++) begin
			if (letter_codes[i] == b) begin
				ch = ctrl ? kbd_pkg::ascii_t'(i + 1) : kbd_pkg::ascii_t'(letters[i]);
				if (!ctrl && (shift ^ m_caps)) ch = ch - 7'h20;
				return 1'b1;
			end
		end
		if (ctrl) return 1'b0;
		for (int i = 0; i < 21; i++) begin
			if (sym_codes[i] == b) begin
				ch = kbd_pkg::ascii_t'(shift ? sym_shift[i] : sym_plain[i]);
				return 1'b1;
			end
		end
		case (b)
			8'h29:   ch = 7'h20; // Space.
			8'h66:   ch = 7'h08;
			8'h0d:   ch = 7'h09;
			8'h5a:   ch = 7'h0d; // Enter gives carriage return.
			8'h76:   ch = 7'h1b;
			default: return 1'b0;
		endcase
		return 1'b1;
	endfunction

	task automatic check_char(input string name, input kbd_pkg::ascii_t exp,
		input kbd_pkg::ascii_t act);
		if (act !== exp) begin
			mismatches++;
			$display("[FAIL] %0t %s expected 0x%02h got 0x%02h", $time, name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input kbd_pkg::kbd_status_t exp,
		input kbd_pkg::kbd_status_t act);
		if (act !== exp) begin
			mismatches++;
			$display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Sends one frame with start, data LSB first, parity and stop. Data moves mid high phase.
	task automatic send_byte(input kbd_pkg::scan_byte_t b, input bit bad_parity,
		input bit dropped);
		logic [10:0]     bits;
		kbd_pkg::ascii_t ch;
		bits = {1'b1, ~^b ^ bad_parity, b, 1'b0};
		frames_sent++;
		if (!bad_parity && !dropped && ref_ascii(b, ch)) begin
			exp_q.push_back(ch);
		end
		for (int i = 0; i < 11; i++) begin
			wait_cycles(HALF_BIT / 2);
			ps2_data = bits[i];
			wait_cycles(HALF_BIT / 2);
			ps2_clk = 1'b0;
			wait_cycles(HALF_BIT);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
	endtask

	task automatic press_key(input kbd_pkg::scan_byte_t code, input bit ext);
		if (ext) send_byte(8'he0, 1'b0, 1'b0);
		send_byte(code, 1'b0, 1'b0);
	endtask

	task automatic release_key(input kbd_pkg::scan_byte_t code, input bit ext);
		if (ext) send_byte(8'he0, 1'b0, 1'b0);
		send_byte(8'hf0, 1'b0, 1'b0);
		send_byte(code, 1'b0, 1'b0);
	endtask

	task automatic type_key(input kbd_pkg::scan_byte_t code, input bit ext);
		press_key(code, ext);
		release_key(code, ext);
	endtask

	task automatic type_random_letter;
		type_key(letter_codes[$urandom_range(0, 25)], 1'b0);
	endtask

	task automatic type_random_symbol;
		type_key(sym_codes[$urandom_range(0, 20)], 1'b0);
	endtask

	task automatic wait_drain;
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		wait_cycles(40); // Leaves room for a stray character.
	endtask

	// Consumer side ready, changed on the falling edge.
	initial begin
		int hold_cnt;
		hold_cnt = 0;
		char_ready = 1'b1;
		forever begin
			@(negedge clk);
			if (ready_mode == 1) begin
				char_ready = 1'b0;
			end else if (ready_mode == 2 && hold_cnt > 0) begin
				hold_cnt--;
				char_ready = 1'b0;
			end else if (ready_mode == 2 && $urandom_range(0, 7) == 0) begin
				hold_cnt = $urandom_range(0, 15);
				char_ready = 1'b0;
			end else begin
				char_ready = 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (!rst && char_valid && char_ready) begin
			chars_seen++;
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("%0t: character 0x%02h arrived while none was expected",
					$time, char_data);
			end else begin
				check_char("char_data", exp_q.pop_front(), char_data);
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > frames_sent * 11 * 40 + 2000) begin
			$display("Timeout after %0d cycles, %0d characters never arrived", cycle_cnt,
				exp_q.size());
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		int mods;
		void'($urandom(32'h4e5b));
		clk = 1'b0;
		rst = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		wait_cycles(4);
		check_status("status", exp_status, status);

		// Letters plain, shifted, under caps lock, then caps lock off again.
		repeat (4) type_random_letter;
		press_key(8'h12, 1'b0);
		repeat (3) type_random_letter;
		release_key(8'h12, 1'b0);
		type_key(8'h58, 1'b0);
		repeat (3) type_random_letter;
		press_key(8'h59, 1'b0);
		repeat (3) type_random_letter;
		release_key(8'h59, 1'b0);
		type_key(8'h58, 1'b0);
		repeat (3) type_random_letter;
		wait_drain;

		// Every symbol key in both forms; caps lock must not matter.
		for (int i = 0; i < 21; i++) type_key(sym_codes[i], 1'b0);
		press_key(8'h59, 1'b0);
		for (int i = 0; i < 21; i++) type_key(sym_codes[i], 1'b0);
		release_key(8'h59, 1'b0);
		type_key(8'h58, 1'b0);
		repeat (4) type_random_symbol;
		press_key(8'h12, 1'b0);
		repeat (4) type_random_symbol;
		release_key(8'h12, 1'b0);
		type_key(8'h58, 1'b0);
		wait_drain;

		// Control codes from both control keys, then a digit under control.
		press_key(8'h14, 1'b0);
		type_key(8'h1c, 1'b0);
		type_key(8'h1a, 1'b0);
		release_key(8'h14, 1'b0);
		press_key(8'h14, 1'b1);
		type_key(8'h2b, 1'b0);
		release_key(8'h14, 1'b1);
		type_key(8'h2b, 1'b0);
		press_key(8'h14, 1'b0);
		type_key(8'h16, 1'b0);
		release_key(8'h14, 1'b0);
		wait_drain;

		// Lone break, extended delete, unmapped keys and a letter after them.
		release_key(8'h1c, 1'b0);
		type_key(8'h71, 1'b1);
		type_key(8'h05, 1'b0);
		type_key(8'h75, 1'b1);
		type_key(8'h1c, 1'b0);
		wait_drain;

		// Space, backspace, tab, enter and escape.
		type_key(8'h29, 1'b0);
		type_key(8'h66, 1'b0);
		type_key(8'h0d, 1'b0);
		type_key(8'h5a, 1'b0);
		type_key(8'h76, 1'b0);
		wait_drain;

		send_byte(8'h1c, 1'b1, 1'b0); // Wrong parity.
		exp_status.frame_error = 1'b1;
		wait_cycles(10);
		check_status("status", exp_status, status);
		type_key(8'h32, 1'b0);
		type_random_letter;
		wait_drain;

		// Fill every buffer stage, then overflow by one frame.
		ready_mode = 1;
		repeat (BUF_CHARS) press_key(letter_codes[$urandom_range(0, 25)], 1'b0);
		wait_cycles(10);
		check_status("status", exp_status, status);
		send_byte(8'h1c, 1'b0, 1'b1);
		exp_status.overrun = 1'b1;
		wait_cycles(10);
		check_status("status", exp_status, status);
		ready_mode = 0;
		wait_drain;

		// Random keys under random modifiers and random consumer stalls.
		ready_mode = 2;
		for (int n = 0; n < 24; n++) begin
			mods = $urandom_range(0, 15);
			if (mods[3]) type_key(8'h58, 1'b0);
			if (mods[0]) press_key(8'h59, 1'b0);
			if (mods[1]) press_key(8'h14, mods[2]);
			if ($urandom_range(0, 1) == 0) type_random_letter;
			else type_random_symbol;
			if (mods[1]) release_key(8'h14, mods[2]);
			if (mods[0]) release_key(8'h59, 1'b0);
		end
		ready_mode = 0;
		wait_drain;
		check_status("status", exp_status, status);

		$display("Characters %0d, mismatches %0d, other errors %0d", chars_seen, mismatches,
			other_errors);
		if (mismatches + other_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+rtl
rtl/kbd_pkg.sv
rtl/ps2_frame_rx.sv
rtl/scan_decoder.sv
rtl/ascii_translator.sv
rtl/char_fifo.sv
rtl/ps2_keyboard_top.sv
verification/ps2_keyboard_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = ps2_keyboard_tb
FILELIST  = sources.f
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
